//--- source/fifo_buf_pkg.sv
package fifo_buf_pkg;

	//////////////////////////////
	// bus width
	//////////////////////////////

	// wishbone data width, one word per access
	localparam int wb_dw = 32;

	//////////////////////////////
	// register map
	//////////////////////////////

	// two-bit word address on wb_adr
	typedef enum logic [1:0] {
		reg_data   = 2'd0,
		reg_status = 2'd1,
		reg_ctrl   = 2'd2
	} reg_addr_e;

	// bus controller states
	typedef enum logic [1:0] {
		st_idle,
		st_read_wait,
		st_ack
	} ctrl_state_e;

	// status word bit positions
	localparam int stat_empty     = 0;
	localparam int stat_full      = 1;
	localparam int stat_aempty    = 2;
	localparam int stat_afull     = 3;
	localparam int stat_ovf       = 4;
	localparam int stat_udf       = 5;
	// occupancy count starts here and runs upward
	localparam int stat_count_lsb = 16;

endpackage

//--- source/fifo_pointers.sv
module fifo_pointers #(
	parameter int depth_log2 = 4
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  clr,
	input  logic                  push,
	input  logic                  pop,
	output logic [depth_log2-1:0] wr_ptr,
	output logic [depth_log2-1:0] rd_ptr,
	output logic                  empty,
	output logic                  full
);

	logic [depth_log2-1:0] wr_ptr_nxt;
	logic [depth_log2-1:0] rd_ptr_nxt;
	// set when the write pointer wraps onto the read pointer
	logic gb;

	// pointers wrap naturally at the power of two
	assign wr_ptr_nxt = wr_ptr + 1'b1;
	assign rd_ptr_nxt = rd_ptr + 1'b1;

	//////////////////////////////
	// write pointer
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			wr_ptr <= '0;
		end else if (clr) begin
			wr_ptr <= '0;
		end else if (push) begin
			wr_ptr <= wr_ptr_nxt;
		end
	end

	//////////////////////////////
	// read pointer
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			rd_ptr <= '0;
		end else if (clr) begin
			rd_ptr <= '0;
		end else if (pop) begin
			rd_ptr <= rd_ptr_nxt;
		end
	end

	//////////////////////////////
	// guard bit
	//////////////////////////////

	// last free slot being filled, pointers will meet as full
	// any pop frees a slot so full is gone
	always_ff @(posedge clk) begin
		if (!rst) begin
			gb <= 1'b0;
		end else if (clr) begin
			gb <= 1'b0;
		end else if (push & (wr_ptr_nxt == rd_ptr)) begin
			gb <= 1'b1;
		end else if (pop) begin
			gb <= 1'b0;
		end
	end

	// equal pointers, guard bit tells full from empty
	assign empty = (wr_ptr == rd_ptr) & !gb;
	assign full  = (wr_ptr == rd_ptr) & gb;

endmodule

//--- source/fifo_ram.sv
module fifo_ram
	import fifo_buf_pkg::*;
#(
	parameter int depth_log2 = 4
) (
	input  logic                  clk,
	input  logic                  push,
	input  logic [depth_log2-1:0] wr_ptr,
	input  logic [depth_log2-1:0] rd_ptr,
	input  logic [wb_dw-1:0]      wdata,
	output logic [wb_dw-1:0]      rdata
);

	// one word per fifo slot
	logic [wb_dw-1:0] mem [2**depth_log2];

	//////////////////////////////
	// write port
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= wdata;
		end
	end

	//////////////////////////////
	// read port
	//////////////////////////////

	// head word is reloaded every cycle
	// so it is already there when a pop comes
	always_ff @(posedge clk) begin
		rdata <= mem[rd_ptr];
	end

endmodule

//--- source/fifo_level.sv
module fifo_level #(
	parameter int depth_log2         = 4,
	parameter int almost_empty_level = 2,
	parameter int almost_full_gap    = 2
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                clr,
	input  logic                push,
	input  logic                pop,
	output logic [depth_log2:0] count,
	output logic                almost_empty,
	output logic                almost_full
);

	localparam int depth = 1 << depth_log2;

	// thresholds at counter width
	localparam logic [depth_log2:0] ae_thr = (depth_log2 + 1)'(almost_empty_level);
	localparam logic [depth_log2:0] af_thr = (depth_log2 + 1)'(depth - almost_full_gap);

	logic [depth_log2:0] count_nxt;

	//////////////////////////////
	// occupancy counter
	//////////////////////////////

	// one extra bit so a full fifo reads as depth
	always_comb begin
		if (clr) begin
			count_nxt = '0;
		end else if (push & !pop) begin
			count_nxt = count + 1'b1;
		end else if (pop & !push) begin
			count_nxt = count - 1'b1;
		end else begin
			count_nxt = count;
		end
	end

	//////////////////////////////
	// registered level flags
	//////////////////////////////

	// flags follow the next count so they agree with count
	// after the same edge
	always_ff @(posedge clk) begin
		if (!rst) begin
			count        <= '0;
			almost_empty <= 1'b1;
			almost_full  <= 1'b0;
		end else begin
			count        <= count_nxt;
			almost_empty <= (count_nxt <= ae_thr);
			almost_full  <= (count_nxt >= af_thr);
		end
	end

endmodule

//--- source/wb_fifo_ctrl.sv
module wb_fifo_ctrl
	import fifo_buf_pkg::*;
#(
	parameter int depth_log2 = 4
) (
	input  logic                 clk,
	input  logic                 rst,
	// wishbone classic slave side
	input  logic                 wb_cyc,
	input  logic                 wb_stb,
	input  logic                 wb_we,
	input  logic [1:0]           wb_adr,
	input  logic [wb_dw-1:0]     wb_dat_i,
	output logic [wb_dw-1:0]     wb_dat_o,
	output logic                 wb_ack,
	// flags and level from the datapath
	input  logic                 empty,
	input  logic                 full,
	input  logic                 almost_empty,
	input  logic                 almost_full,
	input  logic [depth_log2:0]  count,
	input  logic [wb_dw-1:0]     rdata,
	// strobes to the datapath
	output logic                 push,
	output logic                 pop,
	output logic                 clr,
	output logic [wb_dw-1:0]     wdata
);

	ctrl_state_e state;
	reg_addr_e adr;

	logic req;
	logic wr_data_req;
	logic rd_data_req;
	// pop went out for the read now in st_read_wait
	logic pop_q;
	logic ovf;
	logic udf;
	logic [wb_dw-1:0] status;
	logic [wb_dw-1:0] dat_q;

	//////////////////////////////
	// request decode
	//////////////////////////////

	// a new access is only taken in st_idle
	assign req = (state == st_idle) & wb_cyc & wb_stb;
	assign adr = reg_addr_e'(wb_adr);

	assign wr_data_req = req & wb_we & (adr == reg_data);
	assign rd_data_req = req & !wb_we & (adr == reg_data);

	// strobes are single cycle since st_idle is left right after
	assign push = wr_data_req & !full;
	assign pop  = rd_data_req & !empty;
	// ctrl bit 0 clears pointers, count and sticky bits
	assign clr  = req & wb_we & (adr == reg_ctrl) & wb_dat_i[0];

	assign wdata = wb_dat_i;

	//////////////////////////////
	// status word
	//////////////////////////////

	always_comb begin
		status = '0;
		status[stat_empty]  = empty;
		status[stat_full]   = full;
		status[stat_aempty] = almost_empty;
		status[stat_afull]  = almost_full;
		status[stat_ovf]    = ovf;
		status[stat_udf]    = udf;
		status[stat_count_lsb +: depth_log2 + 1] = count;
	end

	//////////////////////////////
	// state machine
	//////////////////////////////

	// data reads take the extra st_read_wait cycle for the ram output
	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= st_idle;
			pop_q <= 1'b0;
		end else begin
			pop_q <= pop;
			case (state)
				st_idle: begin
					if (req) begin
						state <= rd_data_req ? st_read_wait : st_ack;
					end
				end
				st_read_wait: begin
					state <= st_ack;
				end
				st_ack: begin
					state <= st_idle;
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// ack is one cycle wide, master drops stb after seeing it
	assign wb_ack = (state == st_ack);

	//////////////////////////////
	// sticky error bits
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			ovf <= 1'b0;
			udf <= 1'b0;
		end else if (clr) begin
			ovf <= 1'b0;
			udf <= 1'b0;
		end else begin
			// push into a full fifo is dropped
			if (wr_data_req & full) begin
				ovf <= 1'b1;
			end
			// data read with nothing popped
			if ((state == st_read_wait) & !pop_q) begin
				udf <= 1'b1;
			end
		end
	end

	//////////////////////////////
	// read data register
	//////////////////////////////

	// status is sampled at the cycle stb is seen
	// fifo data is taken one cycle later from the ram register
	always_ff @(posedge clk) begin
		if (state == st_read_wait) begin
			dat_q <= pop_q ? rdata : '0;
		end else if (req & !wb_we) begin
			dat_q <= (adr == reg_status) ? status : '0;
		end
	end

	assign wb_dat_o = dat_q;

endmodule

//--- source/wb_fifo_top.sv
module wb_fifo_top
	import fifo_buf_pkg::*;
#(
	parameter int depth_log2         = 4,
	parameter int almost_empty_level = 2,
	parameter int almost_full_gap    = 2
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             wb_cyc,
	input  logic             wb_stb,
	input  logic             wb_we,
	input  logic [1:0]       wb_adr,
	input  logic [wb_dw-1:0] wb_dat_i,
	output logic [wb_dw-1:0] wb_dat_o,
	output logic             wb_ack
);

	// strobes from the bus controller
	logic push;
	logic pop;
	logic clr;
	logic [wb_dw-1:0] wdata;

	// datapath back to the controller
	logic [depth_log2-1:0] wr_ptr;
	logic [depth_log2-1:0] rd_ptr;
	logic empty;
	logic full;
	logic [wb_dw-1:0] rdata;
	logic [depth_log2:0] count;
	logic almost_empty;
	logic almost_full;

	//////////////////////////////
	// bus controller
	//////////////////////////////

	wb_fifo_ctrl #(
		.depth_log2(depth_log2)
	) u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_i    (wb_dat_i),
		.wb_dat_o    (wb_dat_o),
		.wb_ack      (wb_ack),
		.empty       (empty),
		.full        (full),
		.almost_empty(almost_empty),
		.almost_full (almost_full),
		.count       (count),
		.rdata       (rdata),
		.push        (push),
		.pop         (pop),
		.clr         (clr),
		.wdata       (wdata)
	);

	//////////////////////////////
	// datapath
	//////////////////////////////

	fifo_pointers #(
		.depth_log2(depth_log2)
	) u_pointers (
		.clk   (clk),
		.rst   (rst),
		.clr   (clr),
		.push  (push),
		.pop   (pop),
		.wr_ptr(wr_ptr),
		.rd_ptr(rd_ptr),
		.empty (empty),
		.full  (full)
	);

	fifo_ram #(
		.depth_log2(depth_log2)
	) u_ram (
		.clk   (clk),
		.push  (push),
		.wr_ptr(wr_ptr),
		.rd_ptr(rd_ptr),
		.wdata (wdata),
		.rdata (rdata)
	);

	fifo_level #(
		.depth_log2        (depth_log2),
		.almost_empty_level(almost_empty_level),
		.almost_full_gap   (almost_full_gap)
	) u_level (
		.clk         (clk),
		.rst         (rst),
		.clr         (clr),
		.push        (push),
		.pop         (pop),
		.count       (count),
		.almost_empty(almost_empty),
		.almost_full (almost_full)
	);

endmodule

//--- bench/fifo_checker.sv
module fifo_checker #(
	parameter int depth_log2 = 4
) (
	input logic                clk,
	input logic                rst,
	input logic                wb_cyc,
	input logic                wb_stb,
	input logic                wb_ack,
	input logic                push,
	input logic                pop,
	input logic [depth_log2:0] count
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int depth = 1 << depth_log2;

	// failed assertion count
	int fail_count = 0;

	//////////////////////////////
	// bus handshake
	//////////////////////////////

	// ack only answers a live request
	ack_with_req: assert property (@(posedge clk) disable iff (!rst)
		wb_ack |-> (wb_cyc && wb_stb))
	else begin
		$error("wb_ack without cyc and stb");
		fail_count++;
	end

	// single cycle ack
	ack_one_cycle: assert property (@(posedge clk) disable iff (!rst)
		wb_ack |=> !wb_ack)
	else begin
		$error("wb_ack high two cycles in a row");
		fail_count++;
	end

	// one cycle for writes and status, two for data reads
	ack_in_time: assert property (@(posedge clk) disable iff (!rst)
		(wb_cyc && wb_stb && !wb_ack) |-> ##[1:2] wb_ack)
	else begin
		$error("no wb_ack within two cycles of stb");
		fail_count++;
	end

	//////////////////////////////
	// datapath strobes
	//////////////////////////////

	// full and empty judged by the occupancy counter
	// not by the pointer flags that gate the strobes
	push_not_full: assert property (@(posedge clk) disable iff (!rst)
		push |-> (count != depth))
	else begin
		$error("push while full");
		fail_count++;
	end

	pop_not_empty: assert property (@(posedge clk) disable iff (!rst)
		pop |-> (count != 0))
	else begin
		$error("pop while empty");
		fail_count++;
	end

endmodule

// strobes and the count are internal wires of the top level
bind wb_fifo_top fifo_checker #(
	.depth_log2(depth_log2)
) chk (
	.clk   (clk),
	.rst   (rst),
	.wb_cyc(wb_cyc),
	.wb_stb(wb_stb),
	.wb_ack(wb_ack),
	.push  (push),
	.pop   (pop),
	.count (count)
);

//--- bench/fifo_monitor.sv
module fifo_monitor
	import fifo_buf_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic             wb_cyc,
	input  logic             wb_stb,
	input  logic             wb_we,
	input  logic [1:0]       wb_adr,
	input  logic [wb_dw-1:0] wb_dat_i,
	input  logic [wb_dw-1:0] wb_dat_o,
	input  logic             wb_ack,
	// expected read value from the stimulus side
	input  logic             exp_valid,
	input  logic [wb_dw-1:0] exp_data,
	input  logic [8*24-1:0]  test_name,
	output int               value_errs,
	output int               protocol_errs
);

	timeunit 1ns;
	timeprecision 100ps;

	// reference fifo, 16 entries with thresholds 2 and 14
	localparam int depth    = 16;
	localparam int ae_level = 2;
	localparam int af_gap   = 2;

	logic [wb_dw-1:0] model_q [$];
	logic ovf;
	logic udf;

	initial begin
		value_errs    = 0;
		protocol_errs = 0;
		ovf           = 1'b0;
		udf           = 1'b0;
	end

	//////////////////////////////
	// status prediction
	//////////////////////////////

	function automatic logic [wb_dw-1:0] model_status();
		logic [wb_dw-1:0] s;
		int n;
		n = model_q.size();
		s = '0;
		s[stat_empty]  = (n == 0);
		s[stat_full]   = (n == depth);
		s[stat_aempty] = (n <= ae_level);
		s[stat_afull]  = (n >= depth - af_gap);
		s[stat_ovf]    = ovf;
		s[stat_udf]    = udf;
		s[stat_count_lsb +: 16] = 16'(n);
		return s;
	endfunction

	// against the model, then against the golden value
	task automatic compare(input logic [wb_dw-1:0] model_val);
		if (wb_dat_o !== model_val) begin
			$display("Fail %0s expected %h actual %h", test_name, model_val, wb_dat_o);
			value_errs++;
		end
		if (exp_valid && (wb_dat_o !== exp_data)) begin
			$display("Fail %0s expected %h actual %h", test_name, exp_data, wb_dat_o);
			value_errs++;
		end
	endtask

	//////////////////////////////
	// bus watch at ack
	//////////////////////////////

	// request is held until ack so it is all valid here
	always @(posedge clk) begin
		if (rst && wb_ack) begin
			if (!(wb_cyc && wb_stb)) begin
				$display("acknowledge seen while no bus request was pending");
				protocol_errs++;
			end else if (wb_we) begin
				if (wb_adr == reg_data) begin
					// a full fifo drops the word
					if (model_q.size() == depth) begin
						ovf = 1'b1;
					end else begin
						model_q.push_back(wb_dat_i);
					end
				end else if ((wb_adr == reg_ctrl) && wb_dat_i[0]) begin
					model_q.delete();
					ovf = 1'b0;
					udf = 1'b0;
				end
			end else if (wb_adr == reg_data) begin
				if (model_q.size() == 0) begin
					compare('0);
					udf = 1'b1;
				end else begin
					compare(model_q.pop_front());
				end
			end else if (wb_adr == reg_status) begin
				compare(model_status());
			end
		end
	end

endmodule

//--- bench/tb_wb_fifo.sv
module tb_wb_fifo;

	timeunit 1ns;
	timeprecision 100ps;

	logic clk;
	logic rst;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [1:0] wb_adr;
	logic [31:0] wb_dat_i;
	logic [31:0] wb_dat_o;
	logic wb_ack;
	logic exp_valid;
	logic [31:0] exp_data;
	logic [8*24-1:0] test_name;
	int value_errs;
	int protocol_errs;

	// golden lines held in memory
	logic g_we [64];
	logic [1:0] g_adr [64];
	logic [31:0] g_data [64];
	logic [8*24-1:0] g_name [64];
	int n_lines = 0;
	logic load_ok;
	logic [31:0] lfsr = 32'h4cb8_b3b4;
	logic [31:0] words [12];

	wb_fifo_top #(
		.depth_log2        (4),
		.almost_empty_level(2),
		.almost_full_gap   (2)
	) dut (
		.clk     (clk),
		.rst     (rst),
		.wb_cyc  (wb_cyc),
		.wb_stb  (wb_stb),
		.wb_we   (wb_we),
		.wb_adr  (wb_adr),
		.wb_dat_i(wb_dat_i),
		.wb_dat_o(wb_dat_o),
		.wb_ack  (wb_ack)
	);

	fifo_monitor u_monitor (
		.clk          (clk),
		.rst          (rst),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_dat_i     (wb_dat_i),
		.wb_dat_o     (wb_dat_o),
		.wb_ack       (wb_ack),
		.exp_valid    (exp_valid),
		.exp_data     (exp_data),
		.test_name    (test_name),
		.value_errs   (value_errs),
		.protocol_errs(protocol_errs)
	);

	//////////////////////////////
	// clock and watchdog
	//////////////////////////////

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// four cycles per access once reset is released
	initial begin
		@(posedge rst);
		#((n_lines + 24) * 4 * 100);
		$display("timeout, a bus access was never acknowledged");
		$display("RESULT: FAIL");
		$finish;
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	// galois form with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// one lfsr step per bit of the word
	task automatic next_word(output logic [31:0] w);
		w = '0;
		for (int b = 0; b < 32; b++) begin
			w = {w[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	task automatic load_golden();
		int fd;
		int c;
		logic [8*16-1:0] tok;
		fd = $fopen("bench/fifo_golden.txt", "r");
		load_ok = (fd != 0);
		if (fd != 0) begin
			while ($fscanf(fd, "%s", tok) == 1) begin
				if (tok == "#") begin
					// skip the rest of a comment line
					c = $fgetc(fd);
					while ((c != 10) && (c != -1)) begin
						c = $fgetc(fd);
					end
				end else begin
					g_we[n_lines] = (tok == "w");
					c = $fscanf(fd, "%h %h %s", g_adr[n_lines], g_data[n_lines],
						g_name[n_lines]);
					n_lines++;
				end
			end
			$fclose(fd);
		end
	endtask

	// starts 5 ns after an edge, returns 5 ns after the ack edge
	task automatic bus_access(input logic we, input logic [1:0] adr,
			input logic [31:0] data, input logic [8*24-1:0] name);
		wb_cyc    = 1'b1;
		wb_stb    = 1'b1;
		wb_we     = we;
		wb_adr    = adr;
		wb_dat_i  = we ? data : '0;
		exp_valid = !we;
		exp_data  = data;
		test_name = name;
		@(posedge clk);
		while (!wb_ack) begin
			@(posedge clk);
		end
		#5;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		exp_valid = 1'b0;
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		int rd_i;
		rst       = 1'b0;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_adr    = '0;
		wb_dat_i  = '0;
		exp_valid = 1'b0;
		exp_data  = '0;
		test_name = "reset";
		load_golden();
		if (!load_ok) begin
			$display("golden file bench/fifo_golden.txt could not be opened");
			$display("RESULT: FAIL");
			$finish;
		end else begin
			repeat (10) @(posedge clk);
			#5;
			rst = 1'b1;
			for (int i = 0; i < n_lines; i++) begin
				bus_access(g_we[i], g_adr[i], g_data[i], g_name[i]);
			end
			// random words across the pointer wrap with one read per two writes
			rd_i = 0;
			for (int i = 0; i < 12; i++) begin
				next_word(words[i]);
				bus_access(1'b1, 2'd0, words[i], "lfsr_wrap");
				if (i % 2 == 1) begin
					bus_access(1'b0, 2'd0, words[rd_i], "lfsr_wrap");
					rd_i++;
				end
			end
			while (rd_i < 12) begin
				bus_access(1'b0, 2'd0, words[rd_i], "lfsr_wrap");
				rd_i++;
			end
			repeat (3) @(posedge clk);
			$display("value errors %0d, protocol errors %0d, assertion failures %0d",
				value_errs, protocol_errs, dut.chk.fail_count);
			if ((value_errs + protocol_errs + dut.chk.fail_count) == 0) begin
				$display("RESULT: PASS");
			end else begin
				$display("RESULT: FAIL");
			end
			$finish;
		end
	end

endmodule

//--- bench/fifo_golden.txt
# op (w write, r read)  reg (0 data, 1 status, 2 ctrl)  data in hex  test name
# data is the write data for w and the expected read value for r
r 1 00000005 reset_status
r 0 00000000 underflow_rd
r 1 00000025 underflow_status
w 0 a0000001 fill_wr
w 0 a0000002 fill_wr
r 1 00020024 level_c2
w 0 a0000003 fill_wr
r 1 00030020 level_c3
w 0 a0000004 fill_wr
w 0 a0000005 fill_wr
w 0 a0000006 fill_wr
w 0 a0000007 fill_wr
w 0 a0000008 fill_wr
w 0 a0000009 fill_wr
w 0 a000000a fill_wr
w 0 a000000b fill_wr
w 0 a000000c fill_wr
w 0 a000000d fill_wr
r 1 000d0020 level_c13
w 0 a000000e fill_wr
r 1 000e0028 level_c14
w 0 a000000f fill_wr
w 0 a0000010 fill_wr
r 1 0010002a full_status
w 0 deadbeef overflow_wr
r 1 0010003a overflow_status
r 0 a0000001 order_rd
r 0 a0000002 order_rd
r 1 000e0038 level_c14_rd
r 0 a0000003 order_rd
r 1 000d0030 level_c13_rd
w 2 00000001 clear_ctrl
r 1 00000005 clear_status
w 0 b0000001 offset_wr
w 0 b0000002 offset_wr
w 0 b0000003 offset_wr
w 0 b0000004 offset_wr
r 0 b0000001 offset_rd
r 0 b0000002 offset_rd
r 0 b0000003 offset_rd
r 0 b0000004 offset_rd
r 1 00000005 offset_status

//--- files.f
source/fifo_buf_pkg.sv
source/fifo_pointers.sv
source/fifo_ram.sv
source/fifo_level.sv
source/wb_fifo_ctrl.sv
source/wb_fifo_top.sv
bench/fifo_checker.sv
bench/fifo_monitor.sv
bench/tb_wb_fifo.sv

//--- Makefile
TOP := tb_wb_fifo
OBJ := obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f files.f --top-module $(TOP)
	verilator --lint-only --timescale 1ns/100ps -f files.f --top-module wb_fifo_top

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -f files.f \
		--top-module $(TOP) --Mdir $(OBJ)
	./$(OBJ)/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "^RESULT: PASS$$" sim.log

clean:
	rm -rf $(OBJ) sim.log
